// File: all.f
src/mem_pipe_pkg.sv
src/stage_memory1.sv
src/stage_memory2.sv
src/store_data_fwd.sv
src/data_ram.sv
src/mem_pipe_top.sv
bench/mem_pipe_properties.sv
bench/mem_pipe_tb.sv

// File: bench/mem_pipe_tb.sv
/*
 * memory back end testbench
 * plays the execute stage and hazard control with seeded random items,
 * predicts writebacks, branches and memory contents with a byte model
 */

`timescale 1ns/1ps

module mem_pipe_tb;

    import mem_pipe_pkg::*;

    localparam int    CLK_PERIOD = 8;
    localparam int    N_ITEMS    = 2000;
    localparam int    WATCHDOG   = N_ITEMS * CLK_PERIOD * 4;   // ns
    localparam word_t WIN_BASE   = 32'h0000_0100;              // 16 word window

    logic clk, rst_n, stall, flush, in_valid, branch_taken, wb_valid;
    e_to_m1_s in_item;
    word_t    branch_target;
    fwd_s     m1_fwd;
    wb_s      wb;

    int         seed = 11091;
    word_t      pc_next = 32'h0000_1000;
    logic [7:0] mem_model [64];          // byte image of the window
    wb_s        exp_q [$];               // expected writebacks in program order
    logic       m1s_valid, m2s_valid;    // shadows of both stages
    e_to_m1_s   m1s_item;
    wb_s        m2s_wb;                  // what memory2 offers for bypass
    int         checks, errors, wb_count, dut_branches, model_branches;

    mem_pipe_top dut0 (.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .in_valid(in_valid), .in_item(in_item), .branch_taken(branch_taken),
        .branch_target(branch_target), .m1_fwd(m1_fwd), .wb_valid(wb_valid), .wb(wb));

    bind mem_pipe_top mem_pipe_properties props0 (.clk(clk), .rst_n(rst_n), .stall(stall),
        .flush(flush), .wb_valid(wb_valid), .branch_taken(branch_taken), .wb(wb),
        .ram_we(ram_req.we));

    function automatic int rand_int(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic e_to_m1_s random_item(int kind);    // 0 alu 1 csr 2 load 3 store
        e_to_m1_s it;
        int       off;
        it = '0;
        it.pc = pc_next;
        pc_next += 4;
        it.rd_we = (kind != 3);
        it.rd_idx = rand_int(8);
        it.rs2_idx = rand_int(8);
        it.rs2_val = $random(seed);      // possibly stale
        it.alu_result = $random(seed);
        it.csr_old_val = $random(seed);
        it.rd_src = (kind == 1) ? RD_SRC_CSR : (kind == 2) ? RD_SRC_MEM : RD_SRC_ALU;
        it.mem_size = mem_size_e'(rand_int(3));
        it.mem_signed = rand_int(2);
        it.branch_taken = (rand_int(5) == 0);
        it.branch_target = $random(seed) & ~32'h3;
        if (kind >= 2) begin
            off = (it.mem_size == MEM_SIZE_BYTE) ? rand_int(4) :
                  (it.mem_size == MEM_SIZE_HALF) ? 2 * rand_int(2) : 0;  // naturally aligned
            it.alu_result = WIN_BASE + 4 * rand_int(16) + off;
            it.mem_op = (kind == 2) ? MEM_OP_LOAD : MEM_OP_STORE;
        end
        return it;
    endfunction

    // lane n of a little endian word sits at byte address +n
    function automatic word_t load_model(e_to_m1_s it);
        int a;
        a = it.alu_result - WIN_BASE;
        case (it.mem_size)
            MEM_SIZE_BYTE: return it.mem_signed ? {{24{mem_model[a][7]}}, mem_model[a]}
                                                : {24'h0, mem_model[a]};
            MEM_SIZE_HALF: return it.mem_signed ? {{16{mem_model[a+1][7]}}, mem_model[a+1],
                                                   mem_model[a]}
                                                : {16'h0, mem_model[a+1], mem_model[a]};
            default:       return {mem_model[a+3], mem_model[a+2], mem_model[a+1], mem_model[a]};
        endcase
    endfunction

    task automatic commit_item(input e_to_m1_s it);
        wb_s   w;
        word_t sdata;
        int    a;
        int    n;
        a = it.alu_result - WIN_BASE;
        if (it.mem_op == MEM_OP_STORE) begin
            sdata = (m2s_valid && m2s_wb.rd_we && m2s_wb.rd_idx == it.rs2_idx) ? m2s_wb.rd_val
                                                                                : it.rs2_val;
            n = (it.mem_size == MEM_SIZE_BYTE) ? 1 : (it.mem_size == MEM_SIZE_HALF) ? 2 : 4;
            for (int i = 0; i < n; i++) mem_model[a+i] = sdata[8*i +: 8];
        end
        w.rd_we  = it.rd_we && (it.rd_idx != 0);       // x0 never written
        w.rd_idx = it.rd_idx;
        w.pc     = it.pc;
        w.rd_val = (it.rd_src == RD_SRC_MEM) ? load_model(it) :
                   (it.rd_src == RD_SRC_CSR) ? it.csr_old_val : it.alu_result;
        if (it.branch_taken) model_branches++;
        exp_q.push_back(w);
        m2s_wb = w;
    endtask

    task automatic check_outputs();
        wb_s   e;
        word_t fwd_exp;
        check_eq(branch_taken, m1s_valid && !flush && m1s_item.branch_taken, "branch_taken");
        if (branch_taken) check_eq(branch_target, m1s_item.branch_target, "branch_target");
        check_eq(m1_fwd.produces_rd, m1s_valid && m1s_item.rd_we, "m1_fwd.produces_rd");
        if (m1s_valid && m1s_item.rd_we) begin          // bypass record of the memory1 item
            fwd_exp = (m1s_item.rd_src == RD_SRC_CSR) ? m1s_item.csr_old_val
                                                      : m1s_item.alu_result;
            check_eq(m1_fwd.rd_idx, m1s_item.rd_idx, "m1_fwd.rd_idx");
            check_eq(m1_fwd.val_avail, m1s_item.mem_op != MEM_OP_LOAD, "m1_fwd.val_avail");
            if (m1s_item.mem_op != MEM_OP_LOAD) check_eq(m1_fwd.rd_val, fwd_exp, "m1_fwd.rd_val");
        end
        check_eq(wb_valid, m2s_valid, "wb_valid");
        if (branch_taken && !stall) dut_branches++;
        if (wb_valid && !stall) begin                  // last cycle of this item in memory2
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected writeback at %0t while the model expects none", $time);
            end else begin
                e = exp_q.pop_front();
                wb_count++;
                check_eq(wb.pc, e.pc, "wb.pc");
                check_eq(wb.rd_we, e.rd_we, "wb.rd_we");
                check_eq(wb.rd_idx, e.rd_idx, "wb.rd_idx");
                if (e.rd_we) check_eq(wb.rd_val, e.rd_val, "wb.rd_val");
            end
        end
    endtask

    // per clock drive on the falling edge, check and predict the rising edge
    task automatic run_cycle(input bit want, input e_to_m1_s it, input bit rnd, output bit taken);
        logic commit;
        @(negedge clk);
        stall    = rnd && (rand_int(100) < 15);
        flush    = rnd && (rand_int(100) < 5);
        in_valid = want && !(rnd && rand_int(10) == 0);  // occasional bubble
        in_item  = it;
        #1;
        check_outputs();
        taken  = in_valid && !stall;
        commit = !stall && m1s_valid && !flush;
        if (commit) commit_item(m1s_item);
        if (!stall) begin
            m2s_valid = commit;
            m1s_valid = in_valid;
            m1s_item  = in_item;
        end else if (flush) begin
            m1s_valid = 1'b0;                          // dropped while held
        end
    endtask

    task automatic issue_item(input e_to_m1_s it, input bit rnd);
        bit done;
        done = 1'b0;
        while (!done) run_cycle(1'b1, it, rnd, done);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: pipeline did not drain within %0d ns, run aborted", WATCHDOG);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        e_to_m1_s it;
        bit       idle;
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        in_item = '0;
        {m1s_valid, m2s_valid, m1s_item, m2s_wb} = '0;
        {checks, errors, wb_count, dut_branches, model_branches} = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int w = 0; w < 16; w++) begin             // fill the window with word stores
            it = random_item(3);
            it.mem_size = MEM_SIZE_WORD;
            it.alu_result = WIN_BASE + 4 * w;
            it.rs2_idx = '0;
            it.branch_taken = 1'b0;
            issue_item(it, 1'b0);
        end
        for (int n = 0; n < N_ITEMS; n++) issue_item(random_item(rand_int(4)), 1'b1);
        while (exp_q.size() != 0 || m1s_valid || m2s_valid) run_cycle(1'b0, '0, 1'b0, idle);
        check_eq(dut_branches, model_branches, "taken branch count");
        $display("checks %0d, errors %0d, writebacks %0d, taken branches %0d",
                 checks, errors, wb_count, dut_branches);
        if (errors == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    end

endmodule : mem_pipe_tb

// File: bench/mem_pipe_properties.sv
/*
 * memory back end assertions, bound into mem_pipe_top
 * reset clearing, writeback hold under stall, RAM write gating
 */

`timescale 1ns/1ps

module mem_pipe_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              stall,
    input logic              flush,
    input logic              wb_valid,
    input logic              branch_taken,
    input mem_pipe_pkg::wb_s wb,
    input logic              ram_we
);

    // every reset edge clears both valid bits, the first edge after release included
    reset_clears: assert property (@(posedge clk) !rst_n |=> !wb_valid && !branch_taken)
        else $error("wb_valid or branch_taken active after a reset edge");

    // memory2 and the RAM read port hold while stalled
    wb_held: assert property (@(posedge clk) disable iff (!rst_n)
        stall && wb_valid |=> wb_valid && $stable(wb))
        else $error("writeback changed during a stall");

    no_write_when_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> !stall && !flush)
        else $error("RAM write while stall or flush is high");

endmodule : mem_pipe_properties

// File: src/mem_pipe_top.sv
/*
 * memory back end top
 * memory1, memory2, store forwarding and the data RAM
 */

`timescale 1ns/1ps

module mem_pipe_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   in_valid,
    input  mem_pipe_pkg::e_to_m1_s in_item,
    output logic                   branch_taken,
    output mem_pipe_pkg::word_t    branch_target,
    output mem_pipe_pkg::fwd_s     m1_fwd,
    output logic                   wb_valid,
    output mem_pipe_pkg::wb_s      wb
);

    import mem_pipe_pkg::*;

    ram_req_s  ram_req;
    word_t     rdata;
    reg_idx_t  rs2_idx;
    logic      use_fwd;
    word_t     fwd_val;
    logic      m2_valid;
    m1_to_m2_s m2_item;

    stage_memory1 m1 (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_item       (in_item),
        .use_fwd       (use_fwd),
        .fwd_val       (fwd_val),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .m1_fwd        (m1_fwd),
        .rs2_idx       (rs2_idx),
        .ram_req       (ram_req),
        .m2_valid      (m2_valid),
        .m2_item       (m2_item)
    );

    stage_memory2 m2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .in_valid (m2_valid),
        .in_item  (m2_item),
        .rdata    (rdata),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    // writeback of memory2 feeds the store in memory1
    store_data_fwd fwd (
        .m2_valid (wb_valid),
        .m2_wb    (wb),
        .rs2_idx  (rs2_idx),
        .use_fwd  (use_fwd),
        .fwd_val  (fwd_val)
    );

    data_ram ram (
        .clk   (clk),
        .stall (stall),
        .req   (ram_req),
        .rdata (rdata)
    );

endmodule : mem_pipe_top

// File: src/data_ram.sv
/*
 * data RAM
 * single port word memory with byte writes and a registered read port
 */

`timescale 1ns/1ps

module data_ram (
    input  logic                   clk,
    input  logic                   stall,
    input  mem_pipe_pkg::ram_req_s req,
    output mem_pipe_pkg::word_t    rdata
);

    import mem_pipe_pkg::*;

    word_t mem [RAM_DEPTH];           // contents not reset

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (req.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.be[i]) begin
                        mem[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];  // per lane
                    end
                end
            end
            if (req.re) begin
                rdata <= mem[req.addr];   // held while stalled or idle
            end
        end
    end

endmodule : data_ram

// File: src/store_data_fwd.sv
/*
 * store data forwarding
 * bypasses the memory2 writeback into the rs2 of the store in memory1
 */

`timescale 1ns/1ps

module store_data_fwd (
    input  logic                   m2_valid,
    input  mem_pipe_pkg::wb_s      m2_wb,
    input  mem_pipe_pkg::reg_idx_t rs2_idx,
    output logic                   use_fwd,
    output mem_pipe_pkg::word_t    fwd_val
);

    logic hit;                        // same register, nonzero

    assign hit = (m2_wb.rd_idx == rs2_idx) && (m2_wb.rd_idx != 5'd0);

    // memory1 decides whether the store actually needs it
    assign use_fwd = m2_valid && m2_wb.rd_we && hit;
    assign fwd_val = m2_wb.rd_val;    // final value, load data included

endmodule : store_data_fwd

// File: src/stage_memory2.sv
/*
 * memory2 stage
 * aligns and extends load data and selects the register writeback
 */

`timescale 1ns/1ps

module stage_memory2 (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    in_valid,
    input  mem_pipe_pkg::m1_to_m2_s in_item,
    input  mem_pipe_pkg::word_t     rdata,
    output logic                    wb_valid,
    output mem_pipe_pkg::wb_s       wb
);

    import mem_pipe_pkg::*;

    logic       valid_q;
    m1_to_m2_s  item_q;
    logic [1:0] byte_off;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t      load_val;             // aligned and extended
    word_t      rd_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            item_q <= in_item;        // payload only
        end
    end

    assign byte_off = item_q.alu_result[1:0];

    // lane select, rdata is the whole word
    always_comb begin
        unique case (byte_off)
            2'd0:    load_byte = rdata[7:0];
            2'd1:    load_byte = rdata[15:8];
            2'd2:    load_byte = rdata[23:16];
            default: load_byte = rdata[31:24];
        endcase
        load_half = byte_off[1] ? rdata[31:16] : rdata[15:0];
    end

    always_comb begin
        unique case (item_q.mem_size)
            MEM_SIZE_BYTE: begin
                load_val = item_q.mem_signed ? {{24{load_byte[7]}}, load_byte}
                                             : {24'b0, load_byte};
            end
            MEM_SIZE_HALF: begin
                load_val = item_q.mem_signed ? {{16{load_half[15]}}, load_half}
                                             : {16'b0, load_half};
            end
            default: load_val = rdata;
        endcase
    end

    always_comb begin
        unique case (item_q.rd_src)
            RD_SRC_CSR: rd_val = item_q.csr_old_val;
            RD_SRC_MEM: rd_val = load_val;
            default:    rd_val = item_q.alu_result;
        endcase
    end

    assign wb_valid  = valid_q;
    assign wb.rd_we  = valid_q && item_q.rd_we && (item_q.rd_idx != '0);  // x0 stays zero
    assign wb.rd_idx = item_q.rd_idx;
    assign wb.rd_val = rd_val;
    assign wb.pc     = item_q.pc;

endmodule : stage_memory2

// File: src/stage_memory1.sv
/*
 * memory1 stage
 * registers the execute result, issues the data RAM access, reports the
 * resolved branch and publishes the forwarder record
 */

`timescale 1ns/1ps

module stage_memory1 (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   in_valid,
    input  mem_pipe_pkg::e_to_m1_s in_item,
    input  logic                   use_fwd,
    input  mem_pipe_pkg::word_t    fwd_val,
    output logic                   branch_taken,
    output mem_pipe_pkg::word_t    branch_target,
    output mem_pipe_pkg::fwd_s     m1_fwd,
    output mem_pipe_pkg::reg_idx_t rs2_idx,
    output mem_pipe_pkg::ram_req_s ram_req,
    output logic                   m2_valid,
    output mem_pipe_pkg::m1_to_m2_s m2_item
);

    import mem_pipe_pkg::*;

    logic     valid_q;                // item present in memory1
    e_to_m1_s item_q;                 // payload, no reset needed
    logic     live;                   // valid and not being flushed
    word_t    store_val;              // rs2 after bypass
    logic [1:0] byte_off;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;      // advance
        end else if (flush) begin
            valid_q <= 1'b0;          // flushed while held, drop it
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            item_q <= in_item;
        end
    end

    assign live     = valid_q && !flush;
    assign byte_off = item_q.alu_result[1:0];
    assign rs2_idx  = item_q.rs2_idx; // to store_data_fwd

    // stale rs2 replaced when memory2 is writing the same register
    assign store_val = use_fwd ? fwd_val : item_q.rs2_val;

    assign branch_taken  = live && item_q.branch_taken;
    assign branch_target = item_q.branch_target;

    always_comb begin
        ram_req.re   = live && (item_q.mem_op == MEM_OP_LOAD);
        ram_req.we   = live && !stall && (item_q.mem_op == MEM_OP_STORE);  // commit edge only
        ram_req.addr = item_q.alu_result[RAM_ADDR_W+1:2];  // drop byte offset
        unique case (item_q.mem_size)
            MEM_SIZE_BYTE: begin
                ram_req.be    = 4'b0001 << byte_off;
                ram_req.wdata = {4{store_val[7:0]}};
            end
            MEM_SIZE_HALF: begin
                ram_req.be    = byte_off[1] ? 4'b1100 : 4'b0011;
                ram_req.wdata = {2{store_val[15:0]}};
            end
            default: begin    // word
                ram_req.be    = 4'b1111;
                ram_req.wdata = store_val;
            end
        endcase
    end

    always_comb begin
        m1_fwd.produces_rd = valid_q && item_q.rd_we;
        m1_fwd.rd_idx      = item_q.rd_idx;
        m1_fwd.val_avail   = item_q.mem_op != MEM_OP_LOAD;  // load data comes in memory2
        unique case (item_q.rd_src)
            RD_SRC_ALU: m1_fwd.rd_val = item_q.alu_result;
            RD_SRC_CSR: m1_fwd.rd_val = item_q.csr_old_val;
            default:    m1_fwd.rd_val = '0;  // not known yet
        endcase
    end

    assign m2_valid = live;
    always_comb begin
        m2_item = '{
            pc:          item_q.pc,
            rd_src:      item_q.rd_src,
            rd_idx:      item_q.rd_idx,
            rd_we:       item_q.rd_we,
            rs2_idx:     item_q.rs2_idx,
            store_data:  store_val,
            alu_result:  item_q.alu_result,
            csr_old_val: item_q.csr_old_val,
            mem_op:      item_q.mem_op,
            mem_size:    item_q.mem_size,
            mem_signed:  item_q.mem_signed
        };
    end

endmodule : stage_memory1

// File: src/mem_pipe_pkg.sv
/*
 * memory back end package
 * widths, memory op encodings and the records passed between
 * the execute stage, both memory stages, the forwarder and the data RAM
 */

package mem_pipe_pkg;

    localparam int XLEN       = 32;                 // register width
    localparam int RAM_ADDR_W = 8;                  // word address bits
    localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;    // 256 words, 1 KiB

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;             // x0 is never written

    typedef enum logic [1:0] {
        MEM_OP_NOP   = 2'd0,
        MEM_OP_LOAD  = 2'd1,
        MEM_OP_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        RD_SRC_ALU = 2'd0,
        RD_SRC_CSR = 2'd1,
        RD_SRC_MEM = 2'd2
    } rd_src_e;

    // result of the execute stage, captured by memory1
    typedef struct packed {
        word_t     pc;
        rd_src_e   rd_src;
        reg_idx_t  rd_idx;
        logic      rd_we;
        reg_idx_t  rs2_idx;
        word_t     rs2_val;          // may be stale, see store_data_fwd
        word_t     alu_result;       // effective address for loads and stores
        word_t     csr_old_val;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        logic      mem_signed;
        logic      branch_taken;
        word_t     branch_target;
    } e_to_m1_s;

    // memory1 -> memory2, branch info already consumed
    typedef struct packed {
        word_t     pc;
        rd_src_e   rd_src;
        reg_idx_t  rd_idx;
        logic      rd_we;
        reg_idx_t  rs2_idx;
        word_t     store_data;       // rs2 after forwarding
        word_t     alu_result;
        word_t     csr_old_val;
        mem_op_e   mem_op;
        mem_size_e mem_size;
        logic      mem_signed;
    } m1_to_m2_s;

    typedef struct packed {
        logic     rd_we;
        reg_idx_t rd_idx;
        word_t    rd_val;
        word_t    pc;
    } wb_s;

    // what memory1 offers to earlier stages for bypass
    typedef struct packed {
        logic     produces_rd;
        reg_idx_t rd_idx;
        word_t    rd_val;
        logic     val_avail;         // low while a load is still in flight
    } fwd_s;

    typedef struct packed {
        logic                  re;
        logic                  we;
        logic [RAM_ADDR_W-1:0] addr;  // word address
        logic [3:0]            be;    // byte lane enables
        word_t                 wdata; // lane replicated store data
    } ram_req_s;

endpackage : mem_pipe_pkg
